// ==== Makefile ====
TOP := tb_rv_core
LOG := sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f rv_core.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f rv_core.f -Mdir obj_dir
	./obj_dir/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Simulation failed" $(LOG); then echo "FAIL"; exit 1; fi
	@if ! grep -q "Simulation completed successfully" $(LOG); then echo "FAIL"; exit 1; fi
	@echo "PASS"

clean:
	rm -rf obj_dir $(LOG)

// ==== rv_core.f ====
src/rv_core_pkg.sv
src/lsu_req_if.sv
src/rv_decoder.sv
src/rv_alu.sv
src/rv_regfile.sv
src/rv_lsu.sv
src/rv_core.sv
test/rv_core_sva.sv
test/tb_rv_core.sv

// ==== src/lsu_req_if.sv ====
// ------------------------------
// Load/store request channel
// Issue control to LSU, valid/ready
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

interface lsu_req_if import rv_core_pkg::*; ();

  logic      valid;
  logic      ready;
  word_t     addr;
  word_t     wdata;
  logic      write;
  ls_size_e  size;
  logic      is_signed;
  reg_addr_t tag;

  modport issue (
    output valid, addr, wdata, write, size, is_signed, tag,
    input  ready
  );

  modport lsu (
    input  valid, addr, wdata, write, size, is_signed, tag,
    output ready
  );

endinterface

`default_nettype wire

// ==== src/rv_alu.sv ====
// ------------------------------
// RV32I ALU
// Adder, shifter, logic and compare
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module rv_alu import rv_core_pkg::*; (
  input  wire alu_op_e op_i,
  input  wire word_t   opa_i,
  input  wire word_t   opb_i,
  output word_t        result_o
);

  logic        do_sub;
  logic        cmp_signed;
  logic [32:0] add_a;
  logic [32:0] add_b;
  logic [32:0] sum;
  logic        is_zero;
  logic        less;
  logic        shift_left;
  logic        shift_arith;
  word_t       opa_rev;
  word_t       shift_in;
  logic [32:0] shift_ext;
  word_t       shift_out;
  word_t       shl_out;

  // One 33-bit adder for add, sub and all compares
  assign do_sub     = (op_i != alu_add);
  assign cmp_signed = (op_i == alu_lt) || (op_i == alu_ge);
  assign add_a      = {cmp_signed & opa_i[31], opa_i};
  assign add_b      = {cmp_signed & opb_i[31], opb_i};
  assign sum        = add_a + (do_sub ? ~add_b : add_b) + {32'b0, do_sub};
  assign is_zero    = (sum[31:0] == '0);
  assign less       = sum[32];

  // Right shifter, left shifts go through bit reversal
  assign shift_left  = (op_i == alu_sll);
  assign shift_arith = (op_i == alu_sra);
  assign opa_rev     = {<<{opa_i}};
  assign shift_in    = shift_left ? opa_rev : opa_i;
  assign shift_ext   = {shift_arith & shift_in[31], shift_in};
  assign shift_out   = word_t'($signed(shift_ext) >>> opb_i[4:0]);
  assign shl_out     = {<<{shift_out}};

  always_comb begin
    unique case (op_i)
      alu_sll:      result_o = shl_out;
      alu_srl,
      alu_sra:      result_o = shift_out;
      alu_xor:      result_o = opa_i ^ opb_i;
      alu_or:       result_o = opa_i | opb_i;
      alu_and:      result_o = opa_i & opb_i;
      alu_eq:       result_o = {31'b0, is_zero};
      alu_ne:       result_o = {31'b0, ~is_zero};
      alu_lt,
      alu_ltu:      result_o = {31'b0, less};
      alu_ge,
      alu_geu:      result_o = {31'b0, ~less};
      alu_bypass_b: result_o = opb_i;
      default:      result_o = sum[31:0];
    endcase
  end

endmodule

`default_nettype wire

// ==== src/rv_core.sv ====
// ------------------------------
// RV32I integer core
// Single issue with load scoreboard
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module rv_core import rv_core_pkg::*; #(
  parameter word_t       boot_addr             = 32'h0000_1000,
  parameter word_t       trap_addr             = 32'h0000_0100,
  parameter int unsigned num_outstanding_loads = 4
) (
  input  wire logic  clk_i,
  input  wire logic  rst_i,
  // Instruction fetch
  output word_t      inst_addr_o,
  input  wire word_t inst_data_i,
  output logic       inst_valid_o,
  input  wire logic  inst_ready_i,
  // Data port
  output word_t      data_qaddr_o,
  output logic       data_qwrite_o,
  output word_t      data_qdata_o,
  output strb_t      data_qstrb_o,
  output logic       data_qvalid_o,
  input  wire logic  data_qready_i,
  input  wire word_t data_pdata_i,
  input  wire logic  data_pvalid_i
);

  logic        fetch_en_q;
  word_t       pc_q;
  word_t       pc_d;
  logic [31:0] sb_q;
  logic [31:0] sb_d;

  alu_op_e     alu_op;
  opa_sel_e    opa_sel;
  opb_sel_e    opb_sel;
  rd_sel_e     rd_sel;
  next_pc_e    next_pc;
  word_t       imm;
  reg_addr_t   rd;
  reg_addr_t   rs1;
  reg_addr_t   rs2;
  logic        uses_rs1;
  logic        uses_rs2;
  logic        write_rd;
  logic        is_branch;
  logic        is_load;
  logic        is_store;
  logic        is_signed;
  ls_size_e    ls_size;
  logic        illegal;

  word_t       rdata_a;
  word_t       rdata_b;
  word_t       opa;
  word_t       opb;
  word_t       alu_result;
  word_t       link_pc;
  word_t       consec_pc;
  logic        operands_ready;
  logic        valid_instr;
  logic        misaligned;
  logic        exception;
  logic        lsu_stall;
  logic        issue;
  logic        rsp_valid;
  reg_addr_t   rsp_tag;
  word_t       rsp_data;

  lsu_req_if lsu_req ();

  assign inst_addr_o  = pc_q;
  assign inst_valid_o = fetch_en_q;

  rv_decoder i_decoder (
    .instr_i     (inst_data_i),
    .alu_op_o    (alu_op),
    .opa_sel_o   (opa_sel),
    .opb_sel_o   (opb_sel),
    .rd_sel_o    (rd_sel),
    .next_pc_o   (next_pc),
    .imm_o       (imm),
    .rd_o        (rd),
    .rs1_o       (rs1),
    .rs2_o       (rs2),
    .uses_rs1_o  (uses_rs1),
    .uses_rs2_o  (uses_rs2),
    .write_rd_o  (write_rd),
    .is_branch_o (is_branch),
    .is_load_o   (is_load),
    .is_store_o  (is_store),
    .is_signed_o (is_signed),
    .ls_size_o   (ls_size),
    .illegal_o   (illegal)
  );

  // ------------------------------
  // Scoreboard and issue
  // ------------------------------
  // Sources and destination must not wait on a load
  assign operands_ready = !(uses_rs1 && sb_q[rs1]) &&
                          !(uses_rs2 && sb_q[rs2]) &&
                          !((write_rd || is_load) && sb_q[rd]);
  assign valid_instr    = inst_valid_o && inst_ready_i && operands_ready;

  always_comb begin
    unique case (ls_size)
      ls_half: misaligned = alu_result[0];
      ls_word: misaligned = (alu_result[1:0] != 2'b00);
      default: misaligned = 1'b0;
    endcase
    misaligned = misaligned && (is_load || is_store);
  end

  assign exception = illegal || misaligned;
  assign lsu_stall = lsu_req.valid && !lsu_req.ready;
  assign issue     = valid_instr && !lsu_stall;

  always_comb begin
    sb_d = sb_q;
    if (rsp_valid) begin
      sb_d[rsp_tag] = 1'b0;
    end
    if (issue && is_load && !exception) begin
      sb_d[rd] = 1'b1;
    end
    sb_d[0] = 1'b0;
  end

  // ------------------------------
  // Operands and ALU
  // ------------------------------
  always_comb begin
    unique case (opa_sel)
      opa_pc:   opa = pc_q;
      opa_zero: opa = '0;
      default:  opa = rdata_a;
    endcase
  end

  assign opb = (opb_sel == opb_rs2) ? rdata_b : imm;

  rv_alu i_alu (
    .op_i     (alu_op),
    .opa_i    (opa),
    .opb_i    (opb),
    .result_o (alu_result)
  );

  // ------------------------------
  // Next PC
  // ------------------------------
  assign link_pc   = pc_q + 32'd4;
  assign consec_pc = (is_branch && alu_result[0]) ? pc_q + imm : link_pc;

  always_comb begin
    pc_d = pc_q;
    if (issue) begin
      if (exception || next_pc == pc_trap) begin
        pc_d = trap_addr;
      end else if (next_pc == pc_jump) begin
        pc_d = {alu_result[31:1], 1'b0};
      end else begin
        pc_d = consec_pc;
      end
    end
  end

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      fetch_en_q <= 1'b0;
      pc_q       <= boot_addr;
      sb_q       <= '0;
    end else begin
      fetch_en_q <= 1'b1;
      pc_q       <= pc_d;
      sb_q       <= sb_d;
    end
  end

  // ------------------------------
  // Memory and write-back
  // ------------------------------
  assign lsu_req.valid     = valid_instr && (is_load || is_store) && !exception;
  assign lsu_req.addr      = alu_result;
  assign lsu_req.wdata     = rdata_b;
  assign lsu_req.write     = is_store;
  assign lsu_req.size      = ls_size;
  assign lsu_req.is_signed = is_signed;
  assign lsu_req.tag       = rd;

  rv_lsu #(
    .num_outstanding_loads (num_outstanding_loads)
  ) i_lsu (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .req           (lsu_req),
    .rsp_valid_o   (rsp_valid),
    .rsp_tag_o     (rsp_tag),
    .rsp_data_o    (rsp_data),
    .data_qaddr_o  (data_qaddr_o),
    .data_qwrite_o (data_qwrite_o),
    .data_qdata_o  (data_qdata_o),
    .data_qstrb_o  (data_qstrb_o),
    .data_qvalid_o (data_qvalid_o),
    .data_qready_i (data_qready_i),
    .data_pdata_i  (data_pdata_i),
    .data_pvalid_i (data_pvalid_i)
  );

  rv_regfile i_regfile (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .raddr_a_i (rs1),
    .raddr_b_i (rs2),
    .waddr0_i  (rd),
    .wdata0_i  ((rd_sel == rd_link) ? link_pc : alu_result),
    .we0_i     (issue && write_rd && !exception),
    .waddr1_i  (rsp_tag),
    .wdata1_i  (rsp_data),
    .we1_i     (rsp_valid),
    .rdata_a_o (rdata_a),
    .rdata_b_o (rdata_b)
  );

endmodule

`default_nettype wire

// ==== src/rv_core_pkg.sv ====
// ------------------------------
// RV32I core shared definitions
// Word types, control enums and opcodes
// ------------------------------
`default_nettype none

package rv_core_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_addr_t;
  typedef logic [3:0]  strb_t;
  typedef logic [6:0]  opcode_t;
  typedef logic [2:0]  funct3_t;

  typedef enum logic [3:0] {
    alu_add, alu_sub, alu_sll, alu_srl, alu_sra,
    alu_xor, alu_or, alu_and,
    alu_eq, alu_ne, alu_lt, alu_ltu, alu_ge, alu_geu,
    alu_bypass_b
  } alu_op_e;

  typedef enum logic [1:0] {opa_rs1, opa_pc, opa_zero} opa_sel_e;
  typedef enum logic {opb_rs2, opb_imm} opb_sel_e;
  typedef enum logic {rd_alu, rd_link} rd_sel_e;
  typedef enum logic [1:0] {pc_consec, pc_jump, pc_trap} next_pc_e;

  // Encoding follows funct3[1:0] of loads and stores
  typedef enum logic [1:0] {
    ls_byte = 2'b00,
    ls_half = 2'b01,
    ls_word = 2'b10
  } ls_size_e;

  // Major opcodes
  localparam opcode_t opc_load   = 7'b0000011;
  localparam opcode_t opc_op_imm = 7'b0010011;
  localparam opcode_t opc_auipc  = 7'b0010111;
  localparam opcode_t opc_store  = 7'b0100011;
  localparam opcode_t opc_op     = 7'b0110011;
  localparam opcode_t opc_lui    = 7'b0110111;
  localparam opcode_t opc_branch = 7'b1100011;
  localparam opcode_t opc_jalr   = 7'b1100111;
  localparam opcode_t opc_jal    = 7'b1101111;

  // Register and immediate ALU funct3
  localparam funct3_t f3_add  = 3'b000;
  localparam funct3_t f3_sll  = 3'b001;
  localparam funct3_t f3_slt  = 3'b010;
  localparam funct3_t f3_sltu = 3'b011;
  localparam funct3_t f3_xor  = 3'b100;
  localparam funct3_t f3_srl  = 3'b101;
  localparam funct3_t f3_or   = 3'b110;
  localparam funct3_t f3_and  = 3'b111;

  // Branch funct3
  localparam funct3_t f3_beq  = 3'b000;
  localparam funct3_t f3_bne  = 3'b001;
  localparam funct3_t f3_blt  = 3'b100;
  localparam funct3_t f3_bge  = 3'b101;
  localparam funct3_t f3_bltu = 3'b110;
  localparam funct3_t f3_bgeu = 3'b111;

endpackage

`default_nettype wire

// ==== src/rv_decoder.sv ====
// ------------------------------
// RV32I instruction decoder
// Control fields and immediate
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module rv_decoder import rv_core_pkg::*; (
  input  wire word_t instr_i,
  output alu_op_e    alu_op_o,
  output opa_sel_e   opa_sel_o,
  output opb_sel_e   opb_sel_o,
  output rd_sel_e    rd_sel_o,
  output next_pc_e   next_pc_o,
  output word_t      imm_o,
  output reg_addr_t  rd_o,
  output reg_addr_t  rs1_o,
  output reg_addr_t  rs2_o,
  output logic       uses_rs1_o,
  output logic       uses_rs2_o,
  output logic       write_rd_o,
  output logic       is_branch_o,
  output logic       is_load_o,
  output logic       is_store_o,
  output logic       is_signed_o,
  output ls_size_e   ls_size_o,
  output logic       illegal_o
);

  opcode_t     opcode;
  funct3_t     funct3;
  logic [6:0]  funct7;
  word_t       i_imm;
  word_t       s_imm;
  word_t       b_imm;
  word_t       u_imm;
  word_t       j_imm;

  assign opcode = instr_i[6:0];
  assign funct3 = instr_i[14:12];
  assign funct7 = instr_i[31:25];
  assign rd_o   = instr_i[11:7];
  assign rs1_o  = instr_i[19:15];
  assign rs2_o  = instr_i[24:20];

  assign i_imm = {{20{instr_i[31]}}, instr_i[31:20]};
  assign s_imm = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
  assign b_imm = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                  instr_i[11:8], 1'b0};
  assign u_imm = {instr_i[31:12], 12'b0};
  assign j_imm = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                  instr_i[30:21], 1'b0};

  // Shared by register and immediate forms
  function automatic alu_op_e arith_op(funct3_t f3, logic alt);
    case (f3)
      f3_add:  return alt ? alu_sub : alu_add;
      f3_sll:  return alu_sll;
      f3_slt:  return alu_lt;
      f3_sltu: return alu_ltu;
      f3_xor:  return alu_xor;
      f3_srl:  return alt ? alu_sra : alu_srl;
      f3_or:   return alu_or;
      default: return alu_and;
    endcase
  endfunction

  always_comb begin
    alu_op_o    = alu_add;
    opa_sel_o   = opa_rs1;
    opb_sel_o   = opb_imm;
    rd_sel_o    = rd_alu;
    next_pc_o   = pc_consec;
    imm_o       = i_imm;
    uses_rs1_o  = 1'b0;
    uses_rs2_o  = 1'b0;
    write_rd_o  = 1'b0;
    is_branch_o = 1'b0;
    is_load_o   = 1'b0;
    is_store_o  = 1'b0;
    is_signed_o = 1'b0;
    ls_size_o   = ls_word;
    illegal_o   = 1'b0;

    unique case (opcode)
      opc_lui: begin
        write_rd_o = 1'b1;
        alu_op_o   = alu_bypass_b;
        opa_sel_o  = opa_zero;
        imm_o      = u_imm;
      end
      opc_auipc: begin
        write_rd_o = 1'b1;
        opa_sel_o  = opa_pc;
        imm_o      = u_imm;
      end
      opc_jal: begin
        write_rd_o = 1'b1;
        rd_sel_o   = rd_link;
        opa_sel_o  = opa_pc;
        imm_o      = j_imm;
        next_pc_o  = pc_jump;
      end
      opc_jalr: begin
        uses_rs1_o = 1'b1;
        write_rd_o = 1'b1;
        rd_sel_o   = rd_link;
        next_pc_o  = pc_jump;
        illegal_o  = (funct3 != 3'b000);
      end
      opc_branch: begin
        uses_rs1_o  = 1'b1;
        uses_rs2_o  = 1'b1;
        opb_sel_o   = opb_rs2;
        is_branch_o = 1'b1;
        imm_o       = b_imm;
        case (funct3)
          f3_beq:  alu_op_o = alu_eq;
          f3_bne:  alu_op_o = alu_ne;
          f3_blt:  alu_op_o = alu_lt;
          f3_bge:  alu_op_o = alu_ge;
          f3_bltu: alu_op_o = alu_ltu;
          f3_bgeu: alu_op_o = alu_geu;
          default: illegal_o = 1'b1;
        endcase
      end
      opc_load: begin
        uses_rs1_o  = 1'b1;
        is_load_o   = 1'b1;
        is_signed_o = ~funct3[2];
        ls_size_o   = ls_size_e'(funct3[1:0]);
        illegal_o   = (funct3[1:0] == 2'b11) || (funct3[2] && funct3[1]);
      end
      opc_store: begin
        uses_rs1_o = 1'b1;
        uses_rs2_o = 1'b1;
        is_store_o = 1'b1;
        imm_o      = s_imm;
        ls_size_o  = ls_size_e'(funct3[1:0]);
        illegal_o  = funct3[2] || (funct3[1:0] == 2'b11);
      end
      opc_op_imm: begin
        uses_rs1_o = 1'b1;
        write_rd_o = 1'b1;
        alu_op_o   = arith_op(funct3, (funct3 == f3_srl) && funct7[5]);
        if (funct3 == f3_sll) begin
          illegal_o = (funct7 != 7'b0000000);
        end else if (funct3 == f3_srl) begin
          illegal_o = !(funct7 inside {7'b0000000, 7'b0100000});
        end
      end
      opc_op: begin
        uses_rs1_o = 1'b1;
        uses_rs2_o = 1'b1;
        write_rd_o = 1'b1;
        opb_sel_o  = opb_rs2;
        alu_op_o   = arith_op(funct3, funct7[5]);
        illegal_o  = !((funct7 == 7'b0000000) ||
                       (funct7 == 7'b0100000 && funct3 inside {f3_add, f3_srl}));
      end
      default: illegal_o = 1'b1;
    endcase

    // No side effects from an illegal word
    if (illegal_o) begin
      uses_rs1_o  = 1'b0;
      uses_rs2_o  = 1'b0;
      write_rd_o  = 1'b0;
      is_branch_o = 1'b0;
      is_load_o   = 1'b0;
      is_store_o  = 1'b0;
      next_pc_o   = pc_trap;
    end
  end

endmodule

`default_nettype wire

// ==== src/rv_lsu.sv ====
// ------------------------------
// Load/store unit
// Data port requests and in-order load return
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module rv_lsu import rv_core_pkg::*; #(
  parameter int unsigned num_outstanding_loads = 4
) (
  input  wire logic  clk_i,
  input  wire logic  rst_i,
  lsu_req_if.lsu     req,
  output logic       rsp_valid_o,
  output reg_addr_t  rsp_tag_o,
  output word_t      rsp_data_o,
  output word_t      data_qaddr_o,
  output logic       data_qwrite_o,
  output word_t      data_qdata_o,
  output strb_t      data_qstrb_o,
  output logic       data_qvalid_o,
  input  wire logic  data_qready_i,
  input  wire word_t data_pdata_i,
  input  wire logic  data_pvalid_i
);

  localparam int unsigned ptr_w = $clog2(num_outstanding_loads);

  // Load queue payload
  reg_addr_t  tag_q  [num_outstanding_loads];
  ls_size_e   size_q [num_outstanding_loads];
  logic       sign_q [num_outstanding_loads];
  logic [1:0] off_q  [num_outstanding_loads];

  logic [ptr_w-1:0] wr_ptr_q;
  logic [ptr_w-1:0] rd_ptr_q;
  logic [ptr_w:0]   count_q;
  logic             full;
  logic             blocked;
  logic             push;
  logic             pop;
  word_t            rsp_shifted;
  logic             rsp_sign;

  // ------------------------------
  // Request side
  // ------------------------------
  assign full    = (count_q == (ptr_w + 1)'(num_outstanding_loads));
  assign blocked = full && !req.write;

  // Same event on both sides of the LSU
  assign req.ready     = data_qready_i && !blocked;
  assign data_qvalid_o = req.valid && !blocked;
  assign data_qaddr_o  = {req.addr[31:2], 2'b00};
  assign data_qwrite_o = req.write;

  always_comb begin
    unique case (req.size)
      ls_byte: begin
        data_qdata_o = {4{req.wdata[7:0]}};
        data_qstrb_o = strb_t'(4'b0001 << req.addr[1:0]);
      end
      ls_half: begin
        data_qdata_o = {2{req.wdata[15:0]}};
        data_qstrb_o = strb_t'(4'b0011 << req.addr[1:0]);
      end
      default: begin
        data_qdata_o = req.wdata;
        data_qstrb_o = 4'b1111;
      end
    endcase
  end

  assign push = req.valid && req.ready && !req.write;
  assign pop  = data_pvalid_i;

  always_ff @(posedge clk_i) begin
    if (push) begin
      tag_q[wr_ptr_q]  <= req.tag;
      size_q[wr_ptr_q] <= req.size;
      sign_q[wr_ptr_q] <= req.is_signed;
      off_q[wr_ptr_q]  <= req.addr[1:0];
    end
  end

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // ------------------------------
  // Response side
  // ------------------------------
  assign rsp_valid_o = data_pvalid_i;
  assign rsp_tag_o   = tag_q[rd_ptr_q];
  assign rsp_shifted = data_pdata_i >> {off_q[rd_ptr_q], 3'b000};
  assign rsp_sign    = sign_q[rd_ptr_q];

  always_comb begin
    unique case (size_q[rd_ptr_q])
      ls_byte: rsp_data_o = {{24{rsp_sign & rsp_shifted[7]}}, rsp_shifted[7:0]};
      ls_half: rsp_data_o = {{16{rsp_sign & rsp_shifted[15]}}, rsp_shifted[15:0]};
      default: rsp_data_o = rsp_shifted;
    endcase
  end

endmodule

`default_nettype wire

// ==== src/rv_regfile.sv ====
// ------------------------------
// Integer register file
// 2 read, 2 write ports, x0 reads zero
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module rv_regfile import rv_core_pkg::*; (
  input  wire logic      clk_i,
  input  wire logic      rst_i,
  input  wire reg_addr_t raddr_a_i,
  input  wire reg_addr_t raddr_b_i,
  input  wire reg_addr_t waddr0_i,
  input  wire word_t     wdata0_i,
  input  wire logic      we0_i,
  input  wire reg_addr_t waddr1_i,
  input  wire word_t     wdata1_i,
  input  wire logic      we1_i,
  output word_t          rdata_a_o,
  output word_t          rdata_b_o
);

  word_t regs_q [1:31];

  // Port 0 for issue results, port 1 for load data
  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      for (int i = 1; i < 32; i++) begin
        regs_q[i] <= '0;
      end
    end else begin
      if (we0_i && waddr0_i != '0) begin
        regs_q[waddr0_i] <= wdata0_i;
      end
      if (we1_i && waddr1_i != '0) begin
        regs_q[waddr1_i] <= wdata1_i;
      end
    end
  end

  assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs_q[raddr_a_i];
  assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs_q[raddr_b_i];

endmodule

`default_nettype wire

// ==== test/rv_core_input.txt ====
# Columns: tag (I program, M data, E expected store, L load count), address, word, behavior
# Behavior 2: ALU, LUI, AUIPC
I 00001000 06400093 0
I 00001004 FF900113 0
I 00001008 002081B3 0
I 0000100C 30302023 0
I 00001010 40110233 0
I 00001014 30402223 0
I 00001018 00409293 0
I 0000101C 40115313 0
I 00001020 001153B3 0
I 00001024 00112433 0
I 00001028 001134B3 0
I 0000102C 0020C533 0
I 00001030 123455B7 0
I 00001034 00001617 0
I 00001038 30502423 0
I 0000103C 30602623 0
I 00001040 30702823 0
I 00001044 30802A23 0
I 00001048 30902C23 0
I 0000104C 30A02E23 0
I 00001050 32B02023 0
I 00001054 32C02223 0
# Behavior 3: branches, JAL, JALR
I 00001058 00208463 0
I 0000105C 00100693 0
I 00001060 00114463 0
I 00001064 3E002823 0
I 00001068 0020F463 0
I 0000106C 00268693 0
I 00001070 00069463 0
I 00001074 3E002A23 0
I 00001078 00C0076F 0
I 0000107C 3E002C23 0
I 00001080 3E002E23 0
I 00001084 010707E7 0
I 00001088 3E002823 0
I 0000108C 32D02423 0
I 00001090 32E02623 0
I 00001094 32F02823 0
# Behavior 4: loads, SB and SH merge
I 00001098 20100803 0
I 0000109C 20304883 0
I 000010A0 20201903 0
I 000010A4 20005983 0
I 000010A8 20402A03 0
I 000010AC 33002A23 0
I 000010B0 33102C23 0
I 000010B4 33202E23 0
I 000010B8 35302023 0
I 000010BC 35402223 0
I 000010C0 201002A3 0
I 000010C4 20201323 0
I 000010C8 20402A83 0
I 000010CC 35502423 0
# Behavior 5: dependent loads
I 000010D0 20802B03 0
I 000010D4 20C02B83 0
I 000010D8 017B0C33 0
I 000010DC 20C02B03 0
I 000010E0 016C0CB3 0
I 000010E4 35902623 0
I 000010E8 35802823 0
# Behavior 6: illegal word, misaligned LW, trap handler
I 000010EC 05500D93 0
I 000010F0 00000000 0
I 000010F4 20202D83 0
I 00000100 001D0D13 0
I 00000104 35A02C23 0
I 00000108 35B02E23 0
I 0000010C 00100E13 0
I 00000110 01CD1463 0
I 00000114 7E10006F 0
I 00000118 00010EB7 0
I 0000011C FE1EAE23 0
I 00000120 0000006F 0
M 00000200 8081F0F7 0
M 00000204 11223344 0
M 00000208 00000005 0
M 0000020C 00000007 0
E 00000300 0000005D 2
E 00000304 FFFFFF95 2
E 00000308 00000640 2
E 0000030C FFFFFFFC 2
E 00000310 0FFFFFFF 2
E 00000314 00000001 2
E 00000318 00000000 2
E 0000031C FFFFFF9D 2
E 00000320 12345000 2
E 00000324 00002034 2
E 00000328 00000003 3
E 0000032C 0000107C 3
E 00000330 00001088 3
E 00000334 FFFFFFF0 4
E 00000338 00000080 4
E 0000033C FFFF8081 4
E 00000340 0000F0F7 4
E 00000344 11223344 4
E 00000204 11226444 4
E 00000204 FFF96444 4
E 00000348 FFF96444 4
E 0000034C 00000013 5
E 00000350 0000000C 5
E 00000358 00000001 6
E 0000035C 00000055 6
E 00000358 00000002 6
E 0000035C 00000055 6
E 0000FFFC 00000064 6
L 00000000 00000009 6

// ==== test/rv_core_sva.sv ====
// ------------------------------
// RV32I core protocol assertions
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module rv_core_sva import rv_core_pkg::*; (
  input wire logic  clk_i,
  input wire logic  rst_i,
  input wire word_t inst_addr_o,
  input wire logic  inst_valid_o,
  input wire word_t data_qaddr_o,
  input wire logic  data_qwrite_o,
  input wire word_t data_qdata_o,
  input wire strb_t data_qstrb_o,
  input wire logic  data_qvalid_o,
  input wire logic  data_qready_i
);

  // No data traffic while in reset
  reset_quiet: assert property (@(posedge clk_i) rst_i |-> !data_qvalid_o)
    else $error("data request raised during reset");

  // A waiting request may drop but must not change
  request_stable: assert property (@(posedge clk_i) disable iff (rst_i)
    data_qvalid_o && !data_qready_i |=> !data_qvalid_o ||
      $stable({data_qaddr_o, data_qdata_o, data_qstrb_o, data_qwrite_o}))
    else $error("pending data request changed before ready");

  fetch_aligned: assert property (@(posedge clk_i) disable iff (rst_i)
    inst_valid_o |-> inst_addr_o[1:0] == 2'b00)
    else $error("fetch address not word aligned");

endmodule

bind rv_core rv_core_sva u_sva (
  .clk_i         (clk_i),
  .rst_i         (rst_i),
  .inst_addr_o   (inst_addr_o),
  .inst_valid_o  (inst_valid_o),
  .data_qaddr_o  (data_qaddr_o),
  .data_qwrite_o (data_qwrite_o),
  .data_qdata_o  (data_qdata_o),
  .data_qstrb_o  (data_qstrb_o),
  .data_qvalid_o (data_qvalid_o),
  .data_qready_i (data_qready_i)
);

`default_nettype wire

// ==== test/tb_rv_core.sv ====
// ------------------------------
// RV32I core testbench
// Program, data memory model and store checker
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_rv_core import rv_core_pkg::*; ();

  localparam word_t boot_addr = 32'h0000_1000;
  localparam word_t trap_addr = 32'h0000_0100;
  localparam word_t end_addr  = 32'h0000_FFFC;

  logic  clk_i = 1'b0;
  logic  rst_i;
  word_t inst_addr_o;
  word_t inst_data_i;
  logic  inst_valid_o;
  logic  inst_ready_i;
  word_t data_qaddr_o;
  logic  data_qwrite_o;
  word_t data_qdata_o;
  strb_t data_qstrb_o;
  logic  data_qvalid_o;
  logic  data_qready_i;
  word_t data_pdata_i;
  logic  data_pvalid_i;

  // Memory images and expected stores from the input file
  word_t imem [word_t];
  word_t dmem [word_t];
  word_t exp_addr [$];
  word_t exp_data [$];
  int    exp_grp [$];
  // Load responses in flight
  word_t rsp_data [$];
  int    rsp_due [$];

  integer seed = 58265;
  int     errors = 0;
  int     checks = 0;
  int     grp_checks [1:6];
  int     grp_errs [1:6];
  string  beh_name [1:6];
  int     cur_grp = 0;
  int     n_inst = 0;
  int     exp_loads = 0;
  int     load_cnt = 0;
  int     cycle_cnt = 0;
  int     last_due = 0;
  logic   boot_seen = 1'b0;
  logic   pre_boot_req = 1'b0;
  logic   done = 1'b0;

  always #2 clk_i = ~clk_i;

  rv_core #(
    .boot_addr (boot_addr),
    .trap_addr (trap_addr)
  ) u_dut (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .inst_addr_o   (inst_addr_o),
    .inst_data_i   (inst_data_i),
    .inst_valid_o  (inst_valid_o),
    .inst_ready_i  (inst_ready_i),
    .data_qaddr_o  (data_qaddr_o),
    .data_qwrite_o (data_qwrite_o),
    .data_qdata_o  (data_qdata_o),
    .data_qstrb_o  (data_qstrb_o),
    .data_qvalid_o (data_qvalid_o),
    .data_qready_i (data_qready_i),
    .data_pdata_i  (data_pdata_i),
    .data_pvalid_i (data_pvalid_i)
  );

  task automatic check_value(string name, word_t got, word_t exp, int grp);
    checks++;
    grp_checks[grp]++;
    if (got !== exp) begin
      $display("MISMATCH at %0t: %s got %08h expected %08h", $time, name, got, exp);
      errors++;
      grp_errs[grp]++;
    end
  endtask

  task automatic report_behavior(int grp);
    $display("Behavior %0d (%s): %0d checks, %0d errors", grp, beh_name[grp],
             grp_checks[grp], grp_errs[grp]);
  endtask

  // Unwritten words read back a pattern of their own address
  function automatic word_t data_read(word_t addr);
    return dmem.exists(addr) ? dmem[addr] : ~addr;
  endfunction

  // Opcode zero makes a stray fetch trap
  function automatic word_t inst_read(word_t addr);
    return imem.exists(addr) ? imem[addr] : {addr[31:7] ^ addr[24:0], 7'h00};
  endfunction

  task automatic load_input();
    int    fd;
    string line;
    word_t a;
    word_t d;
    int    g;
    fd = $fopen("test/rv_core_input.txt", "r");
    if (fd == 0) begin
      $display("ERROR: cannot open test/rv_core_input.txt");
      errors++;
      return;
    end
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() < 3 || line[0] == "#") begin
        continue;
      end
      g = 0;
      void'($sscanf(line.substr(2, line.len() - 1), "%h %h %d", a, d, g));
      case (line[0])
        "I": begin
          imem[a] = d;
          n_inst++;
        end
        "M": dmem[a] = d;
        "E": begin
          exp_addr.push_back(a);
          exp_data.push_back(d);
          exp_grp.push_back(g);
        end
        "L": exp_loads = int'(d);
        default: begin
          $display("ERROR: unknown line in input file: %s", line);
          errors++;
        end
      endcase
    end
    $fclose(fd);
  endtask

  task automatic check_store(word_t addr, word_t data);
    int grp;
    if (exp_addr.size() == 0) begin
      $display("ERROR: unexpected store of %08h to %08h at %0t", data, addr, $time);
      errors++;
      return;
    end
    grp = exp_grp.pop_front();
    if (grp != cur_grp) begin
      if (cur_grp != 0) begin
        report_behavior(cur_grp);
      end
      cur_grp = grp;
    end
    check_value("data_qaddr_o", addr, exp_addr.pop_front(), grp);
    check_value("stored word", data, exp_data.pop_front(), grp);
  endtask

  // ------------------------------
  // Sample at the rising edge
  // ------------------------------
  always @(posedge clk_i) begin
    word_t merged;
    int    lat;
    if (!rst_i) begin
      if (!boot_seen && data_qvalid_o) begin
        pre_boot_req = 1'b1;
      end
      if (!boot_seen && inst_valid_o) begin
        boot_seen = 1'b1;
        check_value("inst_addr_o", inst_addr_o, boot_addr, 1);
        check_value("data request before boot", {31'b0, pre_boot_req}, '0, 1);
        report_behavior(1);
      end
      if (data_qvalid_o && data_qready_i) begin
        merged = data_read(data_qaddr_o);
        if (data_qwrite_o) begin
          for (int b = 0; b < 4; b++) begin
            if (data_qstrb_o[b]) begin
              merged[8*b +: 8] = data_qdata_o[8*b +: 8];
            end
          end
          dmem[data_qaddr_o] = merged;
          check_store(data_qaddr_o, merged);
          if (data_qaddr_o == end_addr) begin
            done = 1'b1;
          end
        end else begin
          load_cnt++;
          lat = 1 + int'($unsigned($random(seed)) % 3);
          last_due = (cycle_cnt + lat > last_due) ? cycle_cnt + lat : last_due + 1;
          rsp_data.push_back(merged);
          rsp_due.push_back(last_due);
        end
      end
      cycle_cnt++;
    end
  end

  // ------------------------------
  // Drive on the falling edge
  // ------------------------------
  always @(negedge clk_i) begin
    inst_ready_i  = ($random(seed) & 3) != 0;
    data_qready_i = ($random(seed) & 3) != 0;
    inst_data_i   = inst_read(inst_addr_o);
    data_pvalid_i = 1'b0;
    if (rsp_due.size() > 0 && rsp_due[0] <= cycle_cnt) begin
      data_pvalid_i = 1'b1;
      data_pdata_i  = rsp_data.pop_front();
      void'(rsp_due.pop_front());
    end
  end

  initial begin
    int limit;
    rst_i         = 1'b1;
    inst_data_i   = '0;
    inst_ready_i  = 1'b0;
    data_qready_i = 1'b0;
    data_pdata_i  = '0;
    data_pvalid_i = 1'b0;
    beh_name[1] = "reset and boot";
    beh_name[2] = "arithmetic and logic";
    beh_name[3] = "control flow";
    beh_name[4] = "memory access";
    beh_name[5] = "load hazards";
    beh_name[6] = "traps";
    for (int g = 1; g <= 6; g++) begin
      grp_checks[g] = 0;
      grp_errs[g] = 0;
    end
    load_input();
    limit = 40 * n_inst;
    repeat (10) @(posedge clk_i);
    @(negedge clk_i);
    rst_i = 1'b0;
    while (!done && cycle_cnt < limit) begin
      @(negedge clk_i);
    end
    if (!done) begin
      $display("ERROR: final store not seen within %0d cycles", limit);
      errors++;
    end else begin
      check_value("load request count", load_cnt, exp_loads, 6);
      if (exp_addr.size() != 0) begin
        $display("ERROR: %0d expected stores never appeared", exp_addr.size());
        errors++;
      end
    end
    if (cur_grp != 0) begin
      report_behavior(cur_grp);
    end
    $display("Totals: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
